// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_fsq
FILELIST = all.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
rtl/fsq_geom_pkg.sv
rtl/fsq_stream_pkg.sv
rtl/fsq_ifs.sv
rtl/fsq_ptr_ctrl.sv
rtl/fsq_entry.sv
rtl/fsq_readout.sv
rtl/fsq_top.sv
testbench/fsq_asserts.sv
testbench/tb_fsq.sv

// ==== rtl/fsq_entry.sv ====
`timescale 1ns/1ps

module fsq_entry #(
    parameter int unsigned ENTRY_IDX = 0
) (
    input  logic clk,
    input  logic rst,
    stream_write_if.dst wr,
    resolve_if.dst rs,
    entry_rd_if.src rd
);
    localparam fsq_geom_pkg::fsq_idx_t MY_IDX = fsq_geom_pkg::fsq_idx_t'(ENTRY_IDX);

    fsq_stream_pkg::vaddr_t start_addr;
    fsq_stream_pkg::vaddr_t target;
    fsq_stream_pkg::offset_t size;
    logic taken;
    logic res_taken;
    fsq_stream_pkg::vaddr_t res_target;
    fsq_stream_pkg::offset_t res_offset;
    logic pred_error;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_addr <= '0;
            target <= '0;
            size <= '0;
            taken <= 1'b0;
            res_taken <= 1'b0;
            res_target <= '0;
            res_offset <= '0;
            pred_error <= 1'b0;
        end else begin
            if (wr.en && wr.idx == MY_IDX) begin
                start_addr <= wr.start_addr;
                target <= wr.target;
                size <= wr.size;
                taken <= wr.taken;
                pred_error <= 1'b0;
            end
            if (rs.en && rs.idx == MY_IDX) begin
                res_taken <= rs.taken;
                res_target <= rs.target;
                res_offset <= rs.offset;
                pred_error <= 1'b1;
            end
        end
    end

    assign rd.start_addr = start_addr;
    assign rd.target = target;
    assign rd.size = size;
    // backend direction overrides the guess once resolved
    assign rd.taken = pred_error ? res_taken : taken;
    assign rd.pred_error = pred_error;
    assign rd.res_target = res_target;
    assign rd.res_offset = res_offset;

endmodule

// ==== rtl/fsq_geom_pkg.sv ====
package fsq_geom_pkg;

    // queue depth, must stay a power of two for the pointer wrap
    localparam int FSQ_SIZE = 8;
    localparam int FSQ_WIDTH = 3;

    // most instructions the backend retires in one cycle
    localparam int COMMIT_WIDTH = 4;

    typedef logic [FSQ_WIDTH-1:0] fsq_idx_t;

    // msb is the wrap bit
    typedef logic [FSQ_WIDTH:0] fsq_ptr_t;

    typedef logic [$clog2(COMMIT_WIDTH+1)-1:0] commit_num_t;

    // pending committed instructions not yet matched to a stream
    typedef logic [FSQ_WIDTH+1:0] inst_cnt_t;

endpackage

// ==== rtl/fsq_ifs.sv ====
`timescale 1ns/1ps

// enqueue broadcast, one cycle strobe
interface stream_write_if;
    logic en;
    fsq_geom_pkg::fsq_idx_t idx;
    fsq_stream_pkg::vaddr_t start_addr;
    fsq_stream_pkg::vaddr_t target;
    fsq_stream_pkg::offset_t size;
    logic taken;

    modport src (output en, idx, start_addr, target, size, taken);
    modport dst (input en, idx, start_addr, target, size, taken);
endinterface

// backend branch resolution broadcast
interface resolve_if;
    logic en;
    fsq_geom_pkg::fsq_idx_t idx;
    logic taken;
    fsq_stream_pkg::vaddr_t target;
    fsq_stream_pkg::offset_t offset;

    modport src (output en, idx, taken, target, offset);
    modport dst (input en, idx, taken, target, offset);
endinterface

// stored contents of one entry
interface entry_rd_if;
    fsq_stream_pkg::vaddr_t start_addr;
    fsq_stream_pkg::vaddr_t target;
    fsq_stream_pkg::offset_t size;
    logic taken;
    logic pred_error;
    fsq_stream_pkg::vaddr_t res_target;
    fsq_stream_pkg::offset_t res_offset;

    modport src (
        output start_addr, target, size, taken,
        output pred_error, res_target, res_offset
    );
    modport dst (
        input start_addr, target, size, taken,
        input pred_error, res_target, res_offset
    );
endinterface

// ==== rtl/fsq_ptr_ctrl.sv ====
`timescale 1ns/1ps

module fsq_ptr_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic pred_en,
    input  fsq_stream_pkg::vaddr_t pred_start_addr,
    input  fsq_stream_pkg::vaddr_t pred_target,
    input  fsq_stream_pkg::offset_t pred_size,
    input  logic pred_taken,

    input  logic redirect_en,
    input  fsq_geom_pkg::fsq_ptr_t redirect_ptr,
    input  logic redirect_taken,
    input  fsq_stream_pkg::vaddr_t redirect_target,
    input  fsq_stream_pkg::offset_t redirect_offset,

    input  logic cache_ready,
    input  logic commit_valid,

    output logic stall,
    output fsq_geom_pkg::fsq_ptr_t pred_ptr,
    output logic cache_valid,

    output fsq_geom_pkg::fsq_idx_t search_idx,
    output fsq_geom_pkg::fsq_idx_t commit_idx,

    stream_write_if.src wr,
    resolve_if.src rs
);
    fsq_geom_pkg::fsq_ptr_t tail;
    fsq_geom_pkg::fsq_ptr_t search;
    fsq_geom_pkg::fsq_ptr_t commit;
    fsq_geom_pkg::fsq_ptr_t redirect_ptr_n1;
    logic full;
    logic enq;
    logic cache_fire;

    // same slot, different lap
    assign full = (tail[fsq_geom_pkg::FSQ_WIDTH-1:0] == commit[fsq_geom_pkg::FSQ_WIDTH-1:0])
                  && (tail[fsq_geom_pkg::FSQ_WIDTH] != commit[fsq_geom_pkg::FSQ_WIDTH]);

    assign stall = full;
    assign pred_ptr = tail;

    // a stream arriving with a redirect is on the wrong path
    assign enq = pred_en & ~full & ~redirect_en;

    assign cache_valid = (search != tail) & ~redirect_en;
    assign cache_fire = cache_valid & cache_ready;

    assign redirect_ptr_n1 = redirect_ptr + fsq_geom_pkg::fsq_ptr_t'(1);

    assign search_idx = search[fsq_geom_pkg::FSQ_WIDTH-1:0];
    assign commit_idx = commit[fsq_geom_pkg::FSQ_WIDTH-1:0];

    assign wr.en = enq;
    assign wr.idx = tail[fsq_geom_pkg::FSQ_WIDTH-1:0];
    assign wr.start_addr = pred_start_addr;
    assign wr.target = pred_target;
    assign wr.size = pred_size;
    assign wr.taken = pred_taken;

    assign rs.en = redirect_en;
    assign rs.idx = redirect_ptr[fsq_geom_pkg::FSQ_WIDTH-1:0];
    assign rs.taken = redirect_taken;
    assign rs.target = redirect_target;
    assign rs.offset = redirect_offset;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tail <= '0;
            search <= '0;
            commit <= '0;
        end else begin
            // younger streams are dropped, fetch restarts after the resolved one
            if (redirect_en) begin
                tail <= redirect_ptr_n1;
                search <= redirect_ptr_n1;
            end else begin
                if (enq) begin
                    tail <= tail + fsq_geom_pkg::fsq_ptr_t'(1);
                end
                if (cache_fire) begin
                    search <= search + fsq_geom_pkg::fsq_ptr_t'(1);
                end
            end

            if (commit_valid) begin
                commit <= commit + fsq_geom_pkg::fsq_ptr_t'(1);
            end
        end
    end

endmodule

// ==== rtl/fsq_readout.sv ====
`timescale 1ns/1ps

module fsq_readout (
    input  logic clk,
    input  logic rst,

    entry_rd_if.dst ents [fsq_geom_pkg::FSQ_SIZE],

    input  fsq_geom_pkg::fsq_idx_t search_idx,
    input  fsq_geom_pkg::fsq_idx_t commit_idx,
    input  fsq_geom_pkg::commit_num_t commit_num,

    output fsq_stream_pkg::vaddr_t cache_start_addr,
    output fsq_stream_pkg::offset_t cache_size,

    output logic commit_valid,

    output logic update,
    output fsq_stream_pkg::vaddr_t update_start_addr,
    output fsq_stream_pkg::vaddr_t update_target,
    output logic update_taken,
    output logic update_pred_error
);
    fsq_stream_pkg::vaddr_t start_arr [fsq_geom_pkg::FSQ_SIZE];
    fsq_stream_pkg::vaddr_t target_arr [fsq_geom_pkg::FSQ_SIZE];
    fsq_stream_pkg::offset_t size_arr [fsq_geom_pkg::FSQ_SIZE];
    logic taken_arr [fsq_geom_pkg::FSQ_SIZE];
    logic perr_arr [fsq_geom_pkg::FSQ_SIZE];
    fsq_stream_pkg::vaddr_t res_target_arr [fsq_geom_pkg::FSQ_SIZE];
    fsq_stream_pkg::offset_t res_offset_arr [fsq_geom_pkg::FSQ_SIZE];

    logic commit_perr;
    fsq_stream_pkg::offset_t commit_size;
    fsq_geom_pkg::inst_cnt_t inst_cnt;
    fsq_geom_pkg::inst_cnt_t retire_num;

    // flatten the interface array so it can be indexed at run time
    for (genvar i = 0; i < fsq_geom_pkg::FSQ_SIZE; i++) begin : g_flat
        assign start_arr[i] = ents[i].start_addr;
        assign target_arr[i] = ents[i].target;
        assign size_arr[i] = ents[i].size;
        assign taken_arr[i] = ents[i].taken;
        assign perr_arr[i] = ents[i].pred_error;
        assign res_target_arr[i] = ents[i].res_target;
        assign res_offset_arr[i] = ents[i].res_offset;
    end

    assign cache_start_addr = start_arr[search_idx];
    assign cache_size = size_arr[search_idx];

    // a mispredicted stream ends at the resolved branch
    assign commit_perr = perr_arr[commit_idx];
    assign commit_size = commit_perr ? res_offset_arr[commit_idx] : size_arr[commit_idx];

    assign retire_num = fsq_geom_pkg::inst_cnt_t'(commit_size) + fsq_geom_pkg::inst_cnt_t'(1);
    assign commit_valid = inst_cnt > fsq_geom_pkg::inst_cnt_t'(commit_size);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inst_cnt <= '0;
        end else if (commit_valid) begin
            inst_cnt <= inst_cnt + fsq_geom_pkg::inst_cnt_t'(commit_num) - retire_num;
        end else begin
            inst_cnt <= inst_cnt + fsq_geom_pkg::inst_cnt_t'(commit_num);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            update <= 1'b0;
        end else begin
            update <= commit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid) begin
            update_start_addr <= start_arr[commit_idx];
            update_target <= commit_perr ? res_target_arr[commit_idx] : target_arr[commit_idx];
            update_taken <= taken_arr[commit_idx];
            update_pred_error <= commit_perr;
        end
    end

endmodule

// ==== rtl/fsq_stream_pkg.sv ====
package fsq_stream_pkg;

    localparam int VADDR_SIZE = 32;

    // instructions in the largest fetch stream
    localparam int BLOCK_INST_SIZE = 8;
    localparam int PREDICTION_WIDTH = $clog2(BLOCK_INST_SIZE);

    typedef logic [VADDR_SIZE-1:0] vaddr_t;

    // last instruction offset, a stream of size s has s+1 instructions
    typedef logic [PREDICTION_WIDTH-1:0] offset_t;

endpackage

// ==== rtl/fsq_top.sv ====
`timescale 1ns/1ps

module fsq_top (
    input  logic clk,
    input  logic rst,

    input  logic pred_en,
    input  fsq_stream_pkg::vaddr_t pred_start_addr,
    input  fsq_stream_pkg::vaddr_t pred_target,
    input  fsq_stream_pkg::offset_t pred_size,
    input  logic pred_taken,
    output logic stall,
    output fsq_geom_pkg::fsq_ptr_t pred_ptr,

    output logic cache_valid,
    input  logic cache_ready,
    output fsq_stream_pkg::vaddr_t cache_start_addr,
    output fsq_stream_pkg::offset_t cache_size,

    input  logic redirect_en,
    input  fsq_geom_pkg::fsq_ptr_t redirect_ptr,
    input  logic redirect_taken,
    input  fsq_stream_pkg::vaddr_t redirect_target,
    input  fsq_stream_pkg::offset_t redirect_offset,
    output logic squash,
    output fsq_stream_pkg::vaddr_t squash_target,

    input  fsq_geom_pkg::commit_num_t commit_num,

    output logic update,
    output fsq_stream_pkg::vaddr_t update_start_addr,
    output fsq_stream_pkg::vaddr_t update_target,
    output logic update_taken,
    output logic update_pred_error
);
    stream_write_if wr ();
    resolve_if rs ();
    entry_rd_if ents [fsq_geom_pkg::FSQ_SIZE] ();

    fsq_geom_pkg::fsq_idx_t search_idx;
    fsq_geom_pkg::fsq_idx_t commit_idx;
    logic commit_valid;

    fsq_ptr_ctrl u_ptr_ctrl (
        .clk(clk),
        .rst(rst),
        .pred_en(pred_en),
        .pred_start_addr(pred_start_addr),
        .pred_target(pred_target),
        .pred_size(pred_size),
        .pred_taken(pred_taken),
        .redirect_en(redirect_en),
        .redirect_ptr(redirect_ptr),
        .redirect_taken(redirect_taken),
        .redirect_target(redirect_target),
        .redirect_offset(redirect_offset),
        .cache_ready(cache_ready),
        .commit_valid(commit_valid),
        .stall(stall),
        .pred_ptr(pred_ptr),
        .cache_valid(cache_valid),
        .search_idx(search_idx),
        .commit_idx(commit_idx),
        .wr(wr),
        .rs(rs)
    );

    for (genvar i = 0; i < fsq_geom_pkg::FSQ_SIZE; i++) begin : g_entry
        fsq_entry #(
            .ENTRY_IDX(i)
        ) u_entry (
            .clk(clk),
            .rst(rst),
            .wr(wr),
            .rs(rs),
            .rd(ents[i])
        );
    end

    fsq_readout u_readout (
        .clk(clk),
        .rst(rst),
        .ents(ents),
        .search_idx(search_idx),
        .commit_idx(commit_idx),
        .commit_num(commit_num),
        .cache_start_addr(cache_start_addr),
        .cache_size(cache_size),
        .commit_valid(commit_valid),
        .update(update),
        .update_start_addr(update_start_addr),
        .update_target(update_target),
        .update_taken(update_taken),
        .update_pred_error(update_pred_error)
    );

    // predictor restarts from the resolved target one cycle later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            squash <= 1'b0;
        end else begin
            squash <= redirect_en;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_en) begin
            squash_target <= redirect_target;
        end
    end

endmodule

// ==== testbench/fsq_asserts.sv ====
`timescale 1ns/1ps

module fsq_asserts (
    input logic clk,
    input logic rst,
    input logic pred_en,
    input logic stall,
    input logic redirect_en,
    input logic cache_valid,
    input logic cache_ready,
    input logic squash,
    input logic update
);
    // streams enqueued but not yet handed to the cache
    int pending;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= 0;
        end else if (redirect_en) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(pred_en && !stall) - int'(cache_valid && cache_ready);
        end
    end

    a_squash_follows: assert property (@(posedge clk) disable iff (!rst)
        redirect_en |=> squash)
        else $error("squash missing one cycle after redirect_en");

    a_no_fetch_empty: assert property (@(posedge clk) disable iff (!rst)
        (pending == 0) |-> !cache_valid)
        else $error("cache_valid high with an empty queue");

    a_update_in_reset: assert property (@(posedge clk) !rst |-> !update)
        else $error("update high during reset");

endmodule

// ==== testbench/tb_fsq.sv ====
`timescale 1ns/1ps

module tb_fsq;
    localparam int NUM_ROWS = 10;
    localparam int ROW_CYCLES = 40;

    typedef struct {
        logic [31:0] start_addr;
        logic [31:0] target;
        logic [2:0] size;
        logic taken;
        logic redir;
        logic r_taken;
        logic [31:0] r_target;
        logic [2:0] r_offset;
        logic e_upd;
        logic [31:0] e_target;
        logic e_taken;
        logic e_perr;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic pred_en;
    logic [31:0] pred_start_addr;
    logic [31:0] pred_target;
    logic [2:0] pred_size;
    logic pred_taken;
    logic stall;
    logic [3:0] pred_ptr;
    logic cache_valid;
    logic cache_ready;
    logic [31:0] cache_start_addr;
    logic [2:0] cache_size;
    logic redirect_en;
    logic [3:0] redirect_ptr;
    logic redirect_taken;
    logic [31:0] redirect_target;
    logic [2:0] redirect_offset;
    logic squash;
    logic [31:0] squash_target;
    logic [2:0] commit_num;
    logic update;
    logic [31:0] update_start_addr;
    logic [31:0] update_target;
    logic update_taken;
    logic update_pred_error;

    row_t rows [NUM_ROWS];
    int cache_order [$];
    int upd_order [$];
    int cache_seen = 0;
    int fetch_limit = 0;
    int upd_seen = 0;
    int errors = 0;
    int test_err0;
    int tests_run = 0;
    int tests_failed = 0;
    integer seed = 32'hc60e;

    fsq_top DUT (.*);

    bind fsq_top fsq_asserts u_asserts (
        .clk(clk), .rst(rst), .pred_en(pred_en), .stall(stall),
        .redirect_en(redirect_en), .cache_valid(cache_valid),
        .cache_ready(cache_ready), .squash(squash), .update(update)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic load_row(input int i, input logic [31:0] sa, input logic [31:0] tg,
                            input logic [2:0] sz, input logic tk, input logic rd,
                            input logic rtk, input logic [31:0] rtg, input logic [2:0] roff,
                            input logic eu, input logic [31:0] etg, input logic etk,
                            input logic ep);
        rows[i] = '{sa, tg, sz, tk, rd, rtk, rtg, roff, eu, etg, etk, ep};
    endtask

    task automatic begin_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
    endtask

    task automatic enqueue(input int i, input logic [3:0] exp_ptr);
        @(posedge clk);
        pred_en <= 1'b1;
        pred_start_addr <= rows[i].start_addr;
        pred_target <= rows[i].target;
        pred_size <= rows[i].size;
        pred_taken <= rows[i].taken;
        @(negedge clk);
        check_val("enqueue_stall", 32'd0, 32'(stall));
        check_val("enqueue_ptr", 32'(exp_ptr), 32'(pred_ptr));
        @(posedge clk);
        pred_en <= 1'b0;
    endtask

    task automatic commit_insts(input int n);
        int k;
        while (n > 0) begin
            @(posedge clk);
            k = {$random(seed)} % 5;
            if (k > n) begin
                k = n;
            end
            commit_num <= 3'(k);
            n -= k;
        end
        @(posedge clk);
        commit_num <= '0;
    endtask

    // random cache back-pressure, no transfers past the fetch limit
    always @(posedge clk) begin
        cache_ready <= (cache_seen < fetch_limit) && (({$random(seed)} % 4) != 0);
    end

    // cache side scoreboard
    always @(negedge clk) begin
        if (rst && cache_valid && cache_ready) begin
            if (cache_seen >= cache_order.size()) begin
                $display("cache took a stream that was never expected");
                errors++;
            end else begin
                check_val("cache_start_addr", rows[cache_order[cache_seen]].start_addr,
                          cache_start_addr);
                check_val("cache_size", 32'(rows[cache_order[cache_seen]].size),
                          32'(cache_size));
            end
            cache_seen++;
        end
    end

    // predictor update scoreboard
    always @(negedge clk) begin
        if (update) begin
            if (upd_seen >= upd_order.size()) begin
                $display("update pulse arrived with no stream left to retire");
                errors++;
            end else begin
                check_val("update_start_addr", rows[upd_order[upd_seen]].start_addr,
                          update_start_addr);
                check_val("update_target", rows[upd_order[upd_seen]].e_target, update_target);
                check_val("update_taken", 32'(rows[upd_order[upd_seen]].e_taken),
                          32'(update_taken));
                check_val("update_pred_error", 32'(rows[upd_order[upd_seen]].e_perr),
                          32'(update_pred_error));
            end
            upd_seen++;
        end
    end

    initial begin
        #((NUM_ROWS * ROW_CYCLES + 8) * 8);
        $display("watchdog expired before all streams were fetched and retired");
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b0;
        pred_en = 1'b0;
        pred_start_addr = '0;
        pred_target = '0;
        pred_size = '0;
        pred_taken = 1'b0;
        cache_ready = 1'b0;
        redirect_en = 1'b0;
        redirect_ptr = '0;
        redirect_taken = 1'b0;
        redirect_target = '0;
        redirect_offset = '0;
        commit_num = '0;

        // start, target, size, taken, redir, r_taken, r_target, r_offset, upd, exp fields
        load_row(0, 32'h1000, 32'h1040, 3'd3, 1, 0, 0, 32'h0, 3'd0, 1, 32'h1040, 1, 0);
        load_row(1, 32'h1040, 32'h2000, 3'd7, 1, 0, 0, 32'h0, 3'd0, 1, 32'h2000, 1, 0);
        load_row(2, 32'h2000, 32'h2010, 3'd1, 0, 0, 0, 32'h0, 3'd0, 1, 32'h2010, 0, 0);
        load_row(3, 32'h2010, 32'h3000, 3'd5, 1, 0, 0, 32'h0, 3'd0, 1, 32'h3000, 1, 0);
        load_row(4, 32'h3000, 32'h3100, 3'd2, 1, 0, 0, 32'h0, 3'd0, 1, 32'h3100, 1, 0);
        load_row(5, 32'h3100, 32'h4000, 3'd6, 1, 1, 0, 32'h310c, 3'd2, 1, 32'h310c, 0, 1);
        load_row(6, 32'h4000, 32'h4020, 3'd4, 1, 0, 0, 32'h0, 3'd0, 0, 32'h0, 0, 0);
        load_row(7, 32'h4020, 32'h5000, 3'd0, 1, 0, 0, 32'h0, 3'd0, 0, 32'h0, 0, 0);
        load_row(8, 32'h310c, 32'h6000, 3'd3, 1, 0, 0, 32'h0, 3'd0, 1, 32'h6000, 1, 0);
        load_row(9, 32'h6000, 32'h6040, 3'd7, 0, 0, 0, 32'h0, 3'd0, 1, 32'h6040, 0, 0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            // squashed rows never reach the cache or retire
            if (rows[i].e_upd) begin
                cache_order.push_back(i);
                upd_order.push_back(i);
            end
            // younger streams stay unfetched until the squash
            if (rows[i].redir) begin
                fetch_limit = cache_order.size();
            end
        end

        begin_test();
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_val("reset_stall", 32'd0, 32'(stall));
        check_val("reset_cache_valid", 32'd0, 32'(cache_valid));
        check_val("reset_update", 32'd0, 32'(update));
        check_val("reset_squash", 32'd0, 32'(squash));
        end_test("reset");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            enqueue(i, 4'(i));
        end
        @(negedge clk);
        check_val("full_stall", 32'd1, 32'(stall));
        @(posedge clk);
        pred_en <= 1'b1;
        pred_start_addr <= 32'hdead0000;
        @(posedge clk);
        pred_en <= 1'b0;
        @(negedge clk);
        check_val("dropped_ptr", 32'h8, 32'(pred_ptr));
        end_test("fill_and_stall");

        begin_test();
        while (cache_seen < fetch_limit) @(negedge clk);
        end_test("cache_order");

        begin_test();
        commit_insts(int'(rows[0].size) + 1);
        while (upd_seen < 1) @(negedge clk);
        check_val("stall_after_commit", 32'd0, 32'(stall));
        end_test("commit_frees_entry");

        begin_test();
        @(posedge clk);
        redirect_en <= 1'b1;
        redirect_ptr <= 4'd5;
        redirect_taken <= rows[5].r_taken;
        redirect_target <= rows[5].r_target;
        redirect_offset <= rows[5].r_offset;
        @(negedge clk);
        check_val("redirect_cache_valid", 32'd0, 32'(cache_valid));
        @(posedge clk);
        redirect_en <= 1'b0;
        fetch_limit <= cache_order.size();
        @(negedge clk);
        check_val("squash_pulse", 32'd1, 32'(squash));
        check_val("squash_target", rows[5].r_target, squash_target);
        @(negedge clk);
        check_val("squash_end", 32'd0, 32'(squash));
        enqueue(8, 4'd6);
        enqueue(9, 4'd7);
        total = 0;
        for (int i = 1; i < NUM_ROWS; i++) begin
            if (rows[i].e_upd) begin
                total += rows[i].redir ? int'(rows[i].r_offset) + 1 : int'(rows[i].size) + 1;
            end
        end
        commit_insts(total);
        while (upd_seen < upd_order.size() || cache_seen < cache_order.size()) @(negedge clk);
        repeat (20) @(negedge clk);
        check_val("update_count", 32'(upd_order.size()), 32'(upd_seen));
        check_val("cache_count", 32'(cache_order.size()), 32'(cache_seen));
        end_test("redirect_and_retire");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
